//--- common/lc3b_config.svh
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// First fetch address
`define LC3B_RESET_PC 16'h0000

`define LC3B_NUM_REGS 8

// All-zero word, treated as a bubble
`define LC3B_NOP 16'h0000

`endif

//--- common/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

    // Data and address word
    typedef logic [15:0] lc3b_word;

    // Register index
    typedef logic [2:0] lc3b_reg;

    // Full LC-3b opcode map, only part of it is decoded
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // Immediate fields, sign-extended in EX
    typedef logic [4:0] lc3b_imm5;
    typedef logic [5:0] lc3b_offset6;

endpackage : lc3b_isa_pkg

//--- common/lc3b_ctrl_pkg.sv
package lc3b_ctrl_pkg;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // ALU B operand source
    typedef enum logic [1:0] {
        alumux_reg,
        alumux_imm5,
        alumux_off6
    } lc3b_alumux_sel;

    // Write-back source
    typedef enum logic {
        rfmux_alu,
        rfmux_mem
    } lc3b_regfilemux_sel;

    typedef struct packed {
        lc3b_aluop      aluop;
        lc3b_alumux_sel alumux_sel;
        logic           mdrmux_sel;   // 1 = store the second register operand
    } lc3b_control_word_ex;

    typedef struct packed {
        logic d_mem_read;
        logic d_mem_write;
    } lc3b_control_word_mem;

    typedef struct packed {
        logic               load_regfile;
        lc3b_regfilemux_sel regfilemux_sel;
    } lc3b_control_word_wb;

    typedef struct packed {
        lc3b_control_word_ex  ex;
        lc3b_control_word_mem mem;
        lc3b_control_word_wb  wb;
        logic                 src2mux_sel;
    } lc3b_control_word;

    typedef struct packed {
        logic                       valid;
        lc3b_isa_pkg::lc3b_reg      dest;
        lc3b_isa_pkg::lc3b_word     src1_data;
        lc3b_isa_pkg::lc3b_word     src2_data;
        lc3b_isa_pkg::lc3b_imm5     imm5;
        lc3b_isa_pkg::lc3b_offset6  offset6;
        lc3b_control_word_ex        ex;
        lc3b_control_word_mem       mem;
        lc3b_control_word_wb        wb;
    } id_ex_payload;

    typedef struct packed {
        logic                   valid;
        lc3b_isa_pkg::lc3b_reg  dest;
        lc3b_isa_pkg::lc3b_word alu;
        lc3b_isa_pkg::lc3b_word wdata;
        lc3b_control_word_mem   mem;
        lc3b_control_word_wb    wb;
    } ex_mem_payload;

    typedef struct packed {
        logic                   valid;
        lc3b_isa_pkg::lc3b_reg  dest;
        lc3b_isa_pkg::lc3b_word alu;
        lc3b_isa_pkg::lc3b_word mdr;
        lc3b_control_word_wb    wb;
    } mem_wb_payload;

endpackage : lc3b_ctrl_pkg

//--- design/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
    input  lc3b_isa_pkg::lc3b_opcode       opcode,
    input  logic                           ir_4,
    input  logic                           ir_5,
    input  logic                           ir_11,
    output lc3b_ctrl_pkg::lc3b_control_word cw
);

    // Bits 4 and 11 only pick SHF and JSR variants, neither of which is decoded
    always_comb begin
        // Safe default: no register write, no memory strobe
        cw                   = '0;
        cw.ex.aluop          = lc3b_ctrl_pkg::alu_pass;
        cw.ex.alumux_sel     = lc3b_ctrl_pkg::alumux_reg;
        cw.wb.regfilemux_sel = lc3b_ctrl_pkg::rfmux_alu;

        case (opcode)
            lc3b_isa_pkg::op_add,
            lc3b_isa_pkg::op_and: begin
                if (opcode == lc3b_isa_pkg::op_add) begin
                    cw.ex.aluop = lc3b_ctrl_pkg::alu_add;
                end else begin
                    cw.ex.aluop = lc3b_ctrl_pkg::alu_and;
                end
                // Bit 5 picks the imm5 form
                if (ir_5) begin
                    cw.ex.alumux_sel = lc3b_ctrl_pkg::alumux_imm5;
                end
                cw.wb.load_regfile = 1'b1;
            end

            lc3b_isa_pkg::op_not: begin
                cw.ex.aluop        = lc3b_ctrl_pkg::alu_not;
                cw.wb.load_regfile = 1'b1;
            end

            lc3b_isa_pkg::op_ldr: begin
                cw.ex.aluop          = lc3b_ctrl_pkg::alu_add;
                cw.ex.alumux_sel     = lc3b_ctrl_pkg::alumux_off6;
                cw.mem.d_mem_read    = 1'b1;
                cw.wb.load_regfile   = 1'b1;
                cw.wb.regfilemux_sel = lc3b_ctrl_pkg::rfmux_mem;
            end

            lc3b_isa_pkg::op_str: begin
                cw.ex.aluop        = lc3b_ctrl_pkg::alu_add;
                cw.ex.alumux_sel   = lc3b_ctrl_pkg::alumux_off6;
                cw.ex.mdrmux_sel   = 1'b1;
                cw.mem.d_mem_write = 1'b1;
                // Store source sits in the DR field
                cw.src2mux_sel     = 1'b1;
            end

            default: begin
                // NOP and unsupported opcodes keep the default word
            end
        endcase
    end

endmodule : cpu_control

//--- design/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  payload_t in,
    output payload_t out
);

    // Clearing the payload also clears its valid bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out <= '0;
        end else if (load) begin
            out <= in;
        end
    end

endmodule : pipe_reg

//--- design/regfile.sv
`timescale 1ns/1ps
`include "lc3b_config.svh"

module regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,
    input  lc3b_isa_pkg::lc3b_reg  dest,
    input  lc3b_isa_pkg::lc3b_reg  src_a,
    input  lc3b_isa_pkg::lc3b_reg  src_b,
    input  lc3b_isa_pkg::lc3b_word in,
    output lc3b_isa_pkg::lc3b_word reg_a,
    output lc3b_isa_pkg::lc3b_word reg_b
);

    lc3b_isa_pkg::lc3b_word data [`LC3B_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                data[i] <= '0;
            end
        end else if (load) begin
            data[dest] <= in;
        end
    end

    // No bypass, a same-cycle read returns the old value
    assign reg_a = data[src_a];
    assign reg_b = data[src_b];

    // Destination arrives through three pipeline stages
    a_dest_known: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> !$isunknown(dest))
        else $error("register write with unknown destination index");

endmodule : regfile

//--- datapath/cpu_datapath.sv
`timescale 1ns/1ps
`include "lc3b_config.svh"

module cpu_datapath (
    input  logic                            clk,
    input  logic                            rst_n,

    // Control
    input  lc3b_ctrl_pkg::lc3b_control_word cw,
    output lc3b_isa_pkg::lc3b_opcode        opcode,
    output logic                            ir_4,
    output logic                            ir_5,
    output logic                            ir_11,

    // Instruction memory
    input  lc3b_isa_pkg::lc3b_word          i_mem_rdata,
    output lc3b_isa_pkg::lc3b_word          i_mem_address,

    // Data memory
    input  logic                            d_mem_resp,
    input  lc3b_isa_pkg::lc3b_word          d_mem_rdata,
    output lc3b_isa_pkg::lc3b_word          d_mem_address,
    output lc3b_isa_pkg::lc3b_word          d_mem_wdata,
    output logic                            d_mem_read,
    output logic                            d_mem_write
);

    logic load;

    // Stage 1
    lc3b_isa_pkg::lc3b_word pc_out;
    lc3b_isa_pkg::lc3b_word pc_plus2_out;

    // Stage 2
    lc3b_isa_pkg::lc3b_word ir_id;
    lc3b_isa_pkg::lc3b_reg  dest_id;
    lc3b_isa_pkg::lc3b_reg  src1_id;
    lc3b_isa_pkg::lc3b_reg  src2_id;
    lc3b_isa_pkg::lc3b_reg  src2mux_out;
    lc3b_isa_pkg::lc3b_word src1_data_id;
    lc3b_isa_pkg::lc3b_word src2_data_id;
    lc3b_ctrl_pkg::id_ex_payload id_ex_in;
    lc3b_ctrl_pkg::id_ex_payload id_ex_out;

    // Stage 3
    lc3b_isa_pkg::lc3b_word alumux_out;
    lc3b_isa_pkg::lc3b_word alu_ex_out;
    lc3b_ctrl_pkg::ex_mem_payload ex_mem_in;
    lc3b_ctrl_pkg::ex_mem_payload ex_mem_out;

    // Stage 4
    lc3b_ctrl_pkg::mem_wb_payload mem_wb_in;
    lc3b_ctrl_pkg::mem_wb_payload mem_wb_out;

    // Stage 5
    lc3b_isa_pkg::lc3b_word regfilemux_out;
    logic                   load_regfile;

    // Whole pipeline holds while MEM waits on a response
    assign load = ~(d_mem_read | d_mem_write) | d_mem_resp;

    // Stage 1: fetch
    assign pc_plus2_out  = pc_out + 16'd2;
    assign i_mem_address = pc_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_out <= `LC3B_RESET_PC;
        end else if (load) begin
            pc_out <= pc_plus2_out;
        end
    end

    pipe_reg #(.payload_t(lc3b_isa_pkg::lc3b_word)) if_id (
        .clk, .rst_n, .load,
        .in  (i_mem_rdata),
        .out (ir_id)
    );

    // Stage 2: decode and register read
    assign opcode  = lc3b_isa_pkg::lc3b_opcode'(ir_id[15:12]);
    assign dest_id = ir_id[11:9];
    assign src1_id = ir_id[8:6];
    assign src2_id = ir_id[2:0];
    assign ir_4    = ir_id[4];
    assign ir_5    = ir_id[5];
    assign ir_11   = ir_id[11];

    assign src2mux_out = cw.src2mux_sel ? dest_id : src2_id;

    regfile regfile_inst (
        .clk, .rst_n,
        .load  (load_regfile),
        .dest  (mem_wb_out.dest),
        .src_a (src1_id),
        .src_b (src2mux_out),
        .in    (regfilemux_out),
        .reg_a (src1_data_id),
        .reg_b (src2_data_id)
    );

    always_comb begin
        id_ex_in.valid     = (ir_id != `LC3B_NOP);
        id_ex_in.dest      = dest_id;
        id_ex_in.src1_data = src1_data_id;
        id_ex_in.src2_data = src2_data_id;
        id_ex_in.imm5      = ir_id[4:0];
        id_ex_in.offset6   = ir_id[5:0];
        id_ex_in.ex        = cw.ex;
        id_ex_in.mem       = cw.mem;
        id_ex_in.wb        = cw.wb;
    end

    pipe_reg #(.payload_t(lc3b_ctrl_pkg::id_ex_payload)) id_ex (
        .clk, .rst_n, .load,
        .in  (id_ex_in),
        .out (id_ex_out)
    );

    // Stage 3: execute
    always_comb begin
        case (id_ex_out.ex.alumux_sel)
            lc3b_ctrl_pkg::alumux_imm5:
                alumux_out = {{11{id_ex_out.imm5[4]}}, id_ex_out.imm5};
            // Word offset scaled to a byte address
            lc3b_ctrl_pkg::alumux_off6:
                alumux_out = {{9{id_ex_out.offset6[5]}}, id_ex_out.offset6, 1'b0};
            default:
                alumux_out = id_ex_out.src2_data;
        endcase
    end

    always_comb begin
        case (id_ex_out.ex.aluop)
            lc3b_ctrl_pkg::alu_add: alu_ex_out = id_ex_out.src1_data + alumux_out;
            lc3b_ctrl_pkg::alu_and: alu_ex_out = id_ex_out.src1_data & alumux_out;
            lc3b_ctrl_pkg::alu_not: alu_ex_out = ~id_ex_out.src1_data;
            default:                alu_ex_out = alumux_out;
        endcase
    end

    always_comb begin
        ex_mem_in.valid = id_ex_out.valid;
        ex_mem_in.dest  = id_ex_out.dest;
        ex_mem_in.alu   = alu_ex_out;
        ex_mem_in.wdata = id_ex_out.ex.mdrmux_sel ? id_ex_out.src2_data : alu_ex_out;
        ex_mem_in.mem   = id_ex_out.mem;
        ex_mem_in.wb    = id_ex_out.wb;
    end

    pipe_reg #(.payload_t(lc3b_ctrl_pkg::ex_mem_payload)) ex_mem (
        .clk, .rst_n, .load,
        .in  (ex_mem_in),
        .out (ex_mem_out)
    );

    // Stage 4: memory
    assign d_mem_address = ex_mem_out.alu;
    assign d_mem_wdata   = ex_mem_out.wdata;
    assign d_mem_read    = ex_mem_out.valid & ex_mem_out.mem.d_mem_read;
    assign d_mem_write   = ex_mem_out.valid & ex_mem_out.mem.d_mem_write;

    always_comb begin
        mem_wb_in.valid = ex_mem_out.valid;
        mem_wb_in.dest  = ex_mem_out.dest;
        mem_wb_in.alu   = ex_mem_out.alu;
        mem_wb_in.mdr   = d_mem_rdata;
        mem_wb_in.wb    = ex_mem_out.wb;
    end

    pipe_reg #(.payload_t(lc3b_ctrl_pkg::mem_wb_payload)) mem_wb (
        .clk, .rst_n, .load,
        .in  (mem_wb_in),
        .out (mem_wb_out)
    );

    // Stage 5: write-back, once per instruction even across a freeze
    assign regfilemux_out = (mem_wb_out.wb.regfilemux_sel == lc3b_ctrl_pkg::rfmux_mem)
                            ? mem_wb_out.mdr : mem_wb_out.alu;
    assign load_regfile   = load & mem_wb_out.valid & mem_wb_out.wb.load_regfile;

    // Decode never asks for both strobes
    a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(d_mem_read && d_mem_write))
        else $error("data read and write strobes high together");

    // Access stays put until the memory answers
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (d_mem_read || d_mem_write) && !d_mem_resp
        |=> $stable(d_mem_address) && $stable(d_mem_wdata))
        else $error("data address or write data moved while waiting");

endmodule : cpu_datapath

//--- design/cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic                   clk,
    input  logic                   rst_n,

    // Instruction memory
    input  lc3b_isa_pkg::lc3b_word i_mem_rdata,
    output lc3b_isa_pkg::lc3b_word i_mem_address,

    // Data memory
    input  lc3b_isa_pkg::lc3b_word d_mem_rdata,
    input  logic                   d_mem_resp,
    output lc3b_isa_pkg::lc3b_word d_mem_address,
    output lc3b_isa_pkg::lc3b_word d_mem_wdata,
    output logic                   d_mem_read,
    output logic                   d_mem_write
);

    lc3b_ctrl_pkg::lc3b_control_word cw;
    lc3b_isa_pkg::lc3b_opcode        opcode;
    logic                            ir_4;
    logic                            ir_5;
    logic                            ir_11;

    // Decode is combinational on the IF/ID word
    cpu_control control (
        .opcode, .ir_4, .ir_5, .ir_11,
        .cw
    );

    cpu_datapath datapath (
        .clk, .rst_n,
        .cw, .opcode, .ir_4, .ir_5, .ir_11,
        .i_mem_rdata, .i_mem_address,
        .d_mem_resp, .d_mem_rdata,
        .d_mem_address, .d_mem_wdata,
        .d_mem_read, .d_mem_write
    );

endmodule : cpu

//--- testbench/cpu_tb.sv
`timescale 1ns/1ps
`include "lc3b_config.svh"

module cpu_tb;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 64;
    localparam int NUM_INSTR  = 48;
    localparam int PROG_WORDS = NUM_INSTR * 4;
    localparam int LIMIT      = PROG_WORDS * 2 * 4 + 100;
    localparam int LAST_ADDR  = (NUM_INSTR - 1) * 8;
    localparam int NUM_TESTS  = 6;

    typedef struct packed {
        lc3b_isa_pkg::lc3b_word addr;
        lc3b_isa_pkg::lc3b_word data;
        logic                   from_load;
    } store_t;

    logic                   clk;
    logic                   rst_n;
    lc3b_isa_pkg::lc3b_word i_mem_rdata;
    lc3b_isa_pkg::lc3b_word i_mem_address;
    lc3b_isa_pkg::lc3b_word d_mem_rdata;
    logic                   d_mem_resp;
    lc3b_isa_pkg::lc3b_word d_mem_address;
    lc3b_isa_pkg::lc3b_word d_mem_wdata;
    logic                   d_mem_read;
    logic                   d_mem_write;

    lc3b_isa_pkg::lc3b_word imem [IMEM_WORDS];
    lc3b_isa_pkg::lc3b_word dmem [DMEM_WORDS];
    lc3b_isa_pkg::lc3b_word mmem [DMEM_WORDS];
    lc3b_isa_pkg::lc3b_word mreg [8];
    logic                   mreg_ld [8];
    store_t                 exp_q [$];
    store_t                 obs_q [$];

    string test_name [NUM_TESTS] = '{"reset", "pc_advance", "store_data", "load_store",
                                     "hold_stable", "write_count"};
    int    checks [NUM_TESTS];
    int    fails [NUM_TESTS];
    int    wait_left = -1;

    // Monitor state from the previous edge
    logic                   track = 1'b0;
    logic                   prev_wait;
    lc3b_isa_pkg::lc3b_word prev_pc;
    lc3b_isa_pkg::lc3b_word prev_daddr;
    lc3b_isa_pkg::lc3b_word prev_wdata;

    cpu dut (
        .clk, .rst_n,
        .i_mem_rdata, .i_mem_address,
        .d_mem_rdata, .d_mem_resp,
        .d_mem_address, .d_mem_wdata,
        .d_mem_read, .d_mem_write
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Instruction memory answers in the same cycle
    assign i_mem_rdata = (i_mem_address < 16'(IMEM_WORDS * 2))
                         ? imem[i_mem_address[8:1]] : `LC3B_NOP;

    task automatic check(input int id, input logic [15:0] exp, input logic [15:0] act);
        checks[id]++;
        if (exp !== act) begin
            fails[id]++;
            $display("[ERROR] %s: expected %h, actual %h", test_name[id], exp, act);
        end
    endtask

    task automatic report_test(input int id);
        $display("test %-12s %0d checks, %0d mismatches", test_name[id], checks[id], fails[id]);
    endtask

    // Builds the program and runs it in order on the reference model
    task automatic build_program();
        int                     pc_w;
        int                     kind;
        logic [2:0]             dr;
        logic [2:0]             sr1;
        logic [2:0]             sr2;
        logic [4:0]             imm;
        logic [5:0]             off;
        lc3b_isa_pkg::lc3b_word ins;
        lc3b_isa_pkg::lc3b_word simm;
        lc3b_isa_pkg::lc3b_word addr;
        lc3b_isa_pkg::lc3b_word res;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = `LC3B_NOP;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 16'(i) * 16'h9e37 ^ 16'h5a5a;
            mmem[i] = dmem[i];
        end
        pc_w = 0;
        // Setup: ADD Rn, Rn, #imm from cleared registers, R7 stays even
        for (int r = 0; r < 8; r++) begin
            imm = (r == 7) ? 5'($urandom_range(0, 7) * 2) : 5'($urandom_range(0, 31));
            imem[pc_w] = {4'b0001, 3'(r), 3'(r), 1'b1, imm};
            mreg[r] = {{11{imm[4]}}, imm};
            mreg_ld[r] = 1'b0;
            pc_w += 4;
        end
        for (int n = 0; n < NUM_INSTR - 8; n++) begin
            kind = $urandom_range(0, 6);
            dr   = 3'($urandom_range(0, 6));
            sr1  = 3'($urandom_range(0, 7));
            sr2  = 3'($urandom_range(0, 7));
            imm  = 5'($urandom);
            off  = 6'($urandom_range(0, 31));
            simm = {{11{imm[4]}}, imm};
            addr = mreg[7] + {{9{off[5]}}, off, 1'b0};
            case (kind)
                0: begin
                    ins = {4'b0001, dr, sr1, 3'b000, sr2};
                    res = mreg[sr1] + mreg[sr2];
                end
                1: begin
                    ins = {4'b0101, dr, sr1, 3'b000, sr2};
                    res = mreg[sr1] & mreg[sr2];
                end
                2: begin
                    ins = {4'b0001, dr, sr1, 1'b1, imm};
                    res = mreg[sr1] + simm;
                end
                3: begin
                    ins = {4'b0101, dr, sr1, 1'b1, imm};
                    res = mreg[sr1] & simm;
                end
                4: begin
                    ins = {4'b1001, dr, sr1, 6'h3f};
                    res = ~mreg[sr1];
                end
                5: begin
                    ins = {4'b0110, dr, 3'd7, off};
                    mreg[dr] = mmem[addr[6:1]];
                    mreg_ld[dr] = 1'b1;
                end
                default: begin
                    ins = {4'b0111, sr2, 3'd7, off};
                    mmem[addr[6:1]] = mreg[sr2];
                    exp_q.push_back('{addr, mreg[sr2], mreg_ld[sr2]});
                end
            endcase
            if (kind <= 4) begin
                mreg[dr] = res;
                mreg_ld[dr] = 1'b0;
            end
            imem[pc_w] = ins;
            pc_w += 4;
        end
    endtask

    // Data memory with a random response delay
    always @(posedge clk) begin
        if (!rst_n) begin
            d_mem_resp <= 1'b0;
            wait_left = -1;
        end else if (d_mem_resp) begin
            d_mem_resp <= 1'b0;
        end else if (d_mem_read || d_mem_write) begin
            if (wait_left < 0) begin
                wait_left = $urandom_range(0, 3);
            end
            if (wait_left == 0) begin
                d_mem_resp <= 1'b1;
                if (d_mem_write) begin
                    dmem[d_mem_address[6:1]] = d_mem_wdata;
                    obs_q.push_back('{d_mem_address, d_mem_wdata, 1'b0});
                end else begin
                    d_mem_rdata <= dmem[d_mem_address[6:1]];
                end
                wait_left = -1;
            end else begin
                wait_left--;
            end
        end
    end

    // PC step and freeze checks against the previous cycle
    always @(posedge clk) begin
        if (!rst_n) begin
            track = 1'b0;
        end else begin
            if (track) begin
                check(1, prev_wait ? prev_pc : prev_pc + 16'd2, i_mem_address);
                if (prev_wait) begin
                    check(4, prev_pc, i_mem_address);
                    check(4, prev_daddr, d_mem_address);
                    check(4, prev_wdata, d_mem_wdata);
                end
            end
            track      = 1'b1;
            prev_wait  = (d_mem_read || d_mem_write) && !d_mem_resp;
            prev_pc    = i_mem_address;
            prev_daddr = d_mem_address;
            prev_wdata = d_mem_wdata;
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("timeout: program did not finish within %0d cycles", LIMIT);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int id;
        int total_checks;
        int total_fails;
        void'($urandom(26));
        rst_n       = 1'b0;
        d_mem_rdata = '0;
        d_mem_resp  = 1'b0;
        build_program();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check(0, `LC3B_RESET_PC, i_mem_address);
        check(0, 16'd0, {15'd0, d_mem_read});
        check(0, 16'd0, {15'd0, d_mem_write});
        report_test(0);

        // Sampled mid-cycle, where the PC is settled
        while (i_mem_address <= 16'(LAST_ADDR)) begin
            @(negedge clk);
        end
        repeat (8) @(posedge clk);
        report_test(1);
        report_test(4);

        for (int i = 0; i < exp_q.size() && i < obs_q.size(); i++) begin
            id = exp_q[i].from_load ? 3 : 2;
            check(id, exp_q[i].addr, obs_q[i].addr);
            check(id, exp_q[i].data, obs_q[i].data);
        end
        report_test(2);
        report_test(3);
        check(5, 16'(exp_q.size()), 16'(obs_q.size()));
        report_test(5);

        total_checks = 0;
        total_fails  = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_checks += checks[t];
            total_fails  += fails[t];
        end
        $display("%0d tests, %0d checks, %0d mismatches", NUM_TESTS, total_checks, total_fails);
        if (total_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : cpu_tb

//--- lc3b.f
+incdir+common
common/lc3b_isa_pkg.sv
common/lc3b_ctrl_pkg.sv
design/cpu_control.sv
design/pipe_reg.sv
design/regfile.sv
datapath/cpu_datapath.sv
design/cpu.sv
testbench/cpu_tb.sv
